// ==== tb.f ====
+incdir+include
rtl/videoPkg.sv
rtl/cpuBusPkg.sv
rtl/pixelClockGen.sv
rtl/paletteRam.sv
rtl/colorDecode.sv
rtl/pixelOutput.sv
rtl/neoVideoOut.sv
tests/tbNeoVideoOut.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the colour stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
	-f tb.f --top-module tbNeoVideoOut -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/VtbNeoVideoOut
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0

// ==== tests/video_cases.txt ====
# W bank index word  : CPU palette write, all fields hex
# P bank index shadow videoEn hBlank vBlank red green blue : pixel and expected colour, hex
W 0 000 7FFF
W 0 001 0000
W 0 002 8000
W 0 003 FFFF
W 0 004 4000
W 0 005 2000
W 0 006 1000
W 0 007 0A53
W 0 008 8001
W 0 009 9000
W 0 00A 4F00
W 0 123 0F00
W 1 123 00F0
# decode of white, black, extra low bits and the dark bit
P 0 000 0 1 0 0 FF FF FF
P 0 001 0 1 0 0 00 00 00
P 0 002 0 1 0 0 00 00 00
P 0 003 0 1 0 0 FB FB FB
P 0 004 0 1 0 0 08 00 00
P 0 005 0 1 0 0 00 08 00
P 0 006 0 1 0 0 00 00 08
P 0 007 0 1 0 0 A5 52 31
P 0 008 0 1 0 0 00 00 0C
P 0 009 0 1 0 0 00 00 04
P 0 00A 0 1 0 0 FF 00 00
# shadow and video enable
P 0 000 1 1 0 0 7F 7F 7F
P 0 007 1 1 0 0 52 29 18
P 0 003 1 1 0 0 7D 7D 7D
P 0 000 0 0 0 0 00 00 00
P 0 007 1 0 0 0 00 00 00
# banks and a rewrite between pixels
P 0 123 0 1 0 0 F7 00 00
P 1 123 0 1 0 0 00 F7 00
W 0 123 000F
P 0 123 0 1 0 0 00 00 F7
P 1 123 0 1 0 0 00 F7 00
# blank patterns
P 0 000 0 1 1 0 FF FF FF
P 0 007 0 1 0 1 A5 52 31
P 0 000 0 1 1 1 FF FF FF
P 0 001 0 1 0 0 00 00 00
P 0 003 0 1 1 0 FB FB FB

// ==== tests/tbNeoVideoOut.sv ====
`timescale 1ns/1ns
`include "video_cfg.svh"

module tbNeoVideoOut;

	import videoPkg::*;
	import cpuBusPkg::*;

	localparam int MaxPix = 256;
	localparam int MaxWr = 256;

	typedef struct packed {
		logic                    bank;
		logic [`PAL_INDEX_W-1:0] index;
		logic                    shadow;
		logic                    videoEn;
		logic                    hBlank;
		logic                    vBlank;
		logic                    hasFileExp;
		rgb888                   fileExp;
	} pixCase;

	logic               CLK_48M;
	logic               nRESET;
	palWrite            palWr;
	pixelReq            pixIn;
	logic               palBank;
	logic               shadow;
	logic               videoEn;
	pixelOut            pixOut;
	logic               pixelCe;

	pixCase             cases [MaxPix];
	int                 wrEnd [MaxPix];
	pixelOut            expOut [MaxPix];
	palWrite            wrList [MaxWr];
	logic [12:0]        addrList [MaxWr];
	palWord             palModel [2 ** 13];
	int                 pixCount;
	int                 wrCount;

	neoVideoOut i_neoVideoOut (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.palWr   (palWr),
		.pixIn   (pixIn),
		.palBank (palBank),
		.shadow  (shadow),
		.videoEn (videoEn),
		.pixOut  (pixOut),
		.pixelCe (pixelCe)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #2 CLK_48M = ~CLK_48M;
	end

	// ======================================================================
	// Reference model
	// ======================================================================
	function automatic logic [7:0] decodeChannel(input logic [3:0] chan, input logic low,
			input logic dark);
		int lvl;
		lvl = int'(chan) * 4 + int'(low) * 2 + int'(chan[3]);
		if (dark) lvl = lvl - 1;
		if (lvl < 0) lvl = 0;
		// 6-bit level widened to 8 bits with bits 4 and 3 as new LSBs
		return 8'(lvl * 4 + (lvl / 8) % 4);
	endfunction

	function automatic pixelOut expectPixel(input palWord w, input logic sh, input logic en,
			input logic hb, input logic vb);
		rgb888 c;
		c.red = decodeChannel(w[11:8], w[14], w[15]);
		c.green = decodeChannel(w[7:4], w[13], w[15]);
		c.blue = decodeChannel(w[3:0], w[12], w[15]);
		if (sh) c = '{red: c.red >> 1, green: c.green >> 1, blue: c.blue >> 1};
		if (!en) c = '0;
		return '{color: c, hBlank: hb, vBlank: vb};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ======================================================================
	// Checks and pixel timing
	// ======================================================================
	task automatic failRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
	endtask

	// Returns 1 ns after the next edge that samples pixelCe high
	task automatic waitPixelEdge(input int limit, output int cycles);
		cycles = 0;
		while (pixelCe !== 1'b1) begin
			@(posedge CLK_48M);
			#1;
			cycles++;
			if (cycles > limit) failRun("Timeout waiting for the pixel enable");
		end
		@(posedge CLK_48M);
		#1;
		cycles++;
	endtask

	task automatic applyWrite(input palWrite w);
		palWr = w;
		palModel[{w.bank, w.index}] = w.data;
		@(posedge CLK_48M);
		#1;
		palWr = '0;
	endtask

	// ======================================================================
	// Stimulus from the cases file and then random cases
	// ======================================================================
	task automatic loadCases();
		int fd;
		int code;
		logic [7:0] tok;
		logic [8*100-1:0] restLine;
		logic [0:0] bank;
		logic [11:0] index;
		logic [15:0] word;
		logic sh;
		logic en;
		logic hb;
		logic vb;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		fd = $fopen("tests/video_cases.txt", "r");
		if (fd == 0) failRun("Cannot open tests/video_cases.txt for reading");
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) break;
			if (tok == "#") begin
				code = $fgets(restLine, fd);
			end else if (tok == "W") begin
				code = $fscanf(fd, "%h %h %h", bank, index, word);
				if (code != 3) failRun("Malformed write line in the cases file");
				wrList[wrCount] = '{strobe: 1'b1, bank: bank, index: index, data: word};
				addrList[wrCount] = {bank, index};
				wrCount++;
			end else if (tok == "P") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", bank, index, sh, en, hb, vb,
					r, g, b);
				if (code != 9) failRun("Malformed pixel line in the cases file");
				cases[pixCount] = '{bank: bank, index: index, shadow: sh, videoEn: en,
					hBlank: hb, vBlank: vb, hasFileExp: 1'b1,
					fileExp: '{red: r, green: g, blue: b}};
				wrEnd[pixCount] = wrCount;
				pixCount++;
			end else begin
				failRun("Unknown line kind in the cases file");
			end
		end
		$fclose(fd);
	endtask

	// One fresh write per pixel and reads from any word written so far
	task automatic makeRandomCases(input int count);
		logic [31:0] rng;
		logic [12:0] pick;
		rng = 32'd13894;
		for (int n = 0; n < count; n++) begin
			rng = xorshift(rng);
			wrList[wrCount] = '{strobe: 1'b1, bank: rng[0], index: rng[12:1], data: rng[31:16]};
			addrList[wrCount] = {rng[0], rng[12:1]};
			wrCount++;
			rng = xorshift(rng);
			pick = addrList[int'(rng[15:0]) % wrCount];
			cases[pixCount] = '{bank: pick[12], index: pick[11:0], shadow: rng[20] & rng[21],
				videoEn: |rng[24:22], hBlank: rng[25], vBlank: rng[26], hasFileExp: 1'b0,
				fileExp: '0};
			wrEnd[pixCount] = wrCount;
			pixCount++;
		end
	endtask

	initial begin
		int cycles;
		int wrNext;
		pixCase c;
		nRESET = 1'b0;
		palWr = '0;
		pixIn = '0;
		palBank = 1'b0;
		shadow = 1'b0;
		videoEn = 1'b0;
		pixCount = 0;
		wrCount = 0;
		wrNext = 0;
		loadCases();
		makeRandomCases(200);

		// Reset and then the first pixel enable
		repeat (5) begin
			@(posedge CLK_48M);
			#1;
			checkValue("pixOut during reset", 32'd0, 32'(pixOut));
		end
		nRESET = 1'b1;
		waitPixelEdge(`PIXEL_DIV + 2, cycles);
		checkValue("first pixel enable delay", 32'(`PIXEL_DIV), 32'(cycles));
		checkValue("pixOut after first pixel enable", 32'd0, 32'(pixOut));

		// Two pixels in flight with the output settings one enable behind their pixel
		for (int i = 0; i < pixCount + 2; i++) begin
			waitPixelEdge(`PIXEL_DIV + 2, cycles);
			if (i == 0)
				checkValue("pixel enable period", 32'(`PIXEL_DIV), 32'(cycles));
			if (i >= 2)
				checkValue($sformatf("%s case %0d", cases[i - 2].hasFileExp ? "file" : "random",
					i - 2), 32'(expOut[i - 2]), 32'(pixOut));
			if (i >= 1 && i <= pixCount) begin
				shadow = cases[i - 1].shadow;
				videoEn = cases[i - 1].videoEn;
			end
			if (i < pixCount) begin
				c = cases[i];
				while (wrNext < wrEnd[i]) begin
					applyWrite(wrList[wrNext]);
					wrNext++;
				end
				pixIn = '{index: c.index, hBlank: c.hBlank, vBlank: c.vBlank};
				palBank = c.bank;
				expOut[i] = expectPixel(palModel[{c.bank, c.index}], c.shadow, c.videoEn,
					c.hBlank, c.vBlank);
				if (c.hasFileExp)
					checkValue($sformatf("model of file case %0d", i), 32'(c.fileExp),
						32'(expOut[i].color));
			end
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== rtl/neoVideoOut.sv ====
`timescale 1ns/1ns

module neoVideoOut (
	input  logic               CLK_48M,
	input  logic               nRESET,
	input  cpuBusPkg::palWrite palWr,
	input  videoPkg::pixelReq  pixIn,
	input  logic               palBank,
	input  logic               shadow,
	input  logic               videoEn,
	output videoPkg::pixelOut  pixOut,
	output logic               pixelCe
);

	import videoPkg::*;

	// Between palette lookup and output register
	palWord palData;
	logic   palBlankH;
	logic   palBlankV;

	// ======================================================================
	// Dot clock enable that also goes out to the renderer
	// ======================================================================
	pixelClockGen i_pixelClockGen (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.pixelCe (pixelCe)
	);

	// First pipeline stage does the palette lookup
	paletteRam i_paletteRam (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.pixelCe   (pixelCe),
		.palWr     (palWr),
		.pixIn     (pixIn),
		.palBank   (palBank),
		.palData   (palData),
		.blankHOut (palBlankH),
		.blankVOut (palBlankV)
	);

	// Second stage decodes and registers on the next dot
	pixelOutput i_pixelOutput (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.pixelCe (pixelCe),
		.palData (palData),
		.blankH  (palBlankH),
		.blankV  (palBlankV),
		.shadow  (shadow),
		.videoEn (videoEn),
		.pixOut  (pixOut)
	);

endmodule

// ==== rtl/pixelOutput.sv ====
`timescale 1ns/1ns

module pixelOutput (
	input  logic             CLK_48M,
	input  logic             nRESET,
	input  logic             pixelCe,
	input  videoPkg::palWord palData,
	input  logic             blankH,
	input  logic             blankV,
	input  logic             shadow,
	input  logic             videoEn,
	output videoPkg::pixelOut pixOut
);

	import videoPkg::*;

	logic [7:0] redDec;
	logic [7:0] greenDec;
	logic [7:0] blueDec;
	rgb888      adjusted;

	// Shadow halves the level and disabled video blacks it out
	function automatic logic [7:0] shade(
		input logic [7:0] level,
		input logic       halve,
		input logic       enable
	);
		logic [7:0] result;
		result = halve ? {1'b0, level[7:1]} : level;
		return enable ? result : 8'd0;
	endfunction

	// ======================================================================
	// Per-channel decode with the dark bit shared by all three
	// ======================================================================
	colorDecode i_redDecode (
		.chanBits (palData[11:8]),
		.lowBit   (palData[14]),
		.dark     (palData[15]),
		.chan8    (redDec)
	);

	colorDecode i_greenDecode (
		.chanBits (palData[7:4]),
		.lowBit   (palData[13]),
		.dark     (palData[15]),
		.chan8    (greenDec)
	);

	colorDecode i_blueDecode (
		.chanBits (palData[3:0]),
		.lowBit   (palData[12]),
		.dark     (palData[15]),
		.chan8    (blueDec)
	);

	assign adjusted = '{
		red:   shade(redDec, shadow, videoEn),
		green: shade(greenDec, shadow, videoEn),
		blue:  shade(blueDec, shadow, videoEn)
	};

	// ======================================================================
	// Output register that updates once per dot
	// ======================================================================
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			pixOut <= '0;
		end else if (pixelCe) begin
			pixOut <= '{color: adjusted, hBlank: blankH, vBlank: blankV};
		end
	end

endmodule

// ==== rtl/colorDecode.sv ====
`timescale 1ns/1ns

module colorDecode (
	input  logic [3:0] chanBits,
	input  logic       lowBit,
	input  logic       dark,
	output logic [7:0] chan8
);

	logic [5:0] level6;
	logic [6:0] darkened;
	logic [5:0] clamped;

	// Channel MSB is repeated below the extra bit, so full scale is all ones
	assign level6 = {chanBits, lowBit, chanBits[3]};

	// One guard bit on top catches the borrow from the dark step
	assign darkened = {1'b0, level6} - {6'd0, dark};

	// Below zero only happens for an all-zero level with dark set
	assign clamped = darkened[6] ? 6'd0 : darkened[5:0];

	// Bits 4 and 3 fill the two new LSBs so 6-bit white stays 8-bit white
	assign chan8 = {clamped, clamped[4:3]};

endmodule

// ==== rtl/paletteRam.sv ====
`timescale 1ns/1ns
`include "video_cfg.svh"

module paletteRam (
	input  logic               CLK_48M,
	input  logic               nRESET,
	input  logic               pixelCe,
	input  cpuBusPkg::palWrite palWr,
	input  videoPkg::pixelReq  pixIn,
	input  logic               palBank,
	output videoPkg::palWord   palData,
	output logic               blankHOut,
	output logic               blankVOut
);

	import videoPkg::*;

	localparam int BankW = $clog2(`PAL_BANKS);
	localparam int AddrW = BankW + `PAL_INDEX_W;
	localparam int Depth = `PAL_BANKS * (2 ** `PAL_INDEX_W);

	palWord           palMem [Depth];
	logic [AddrW-1:0] wrAddr;
	logic [AddrW-1:0] rdAddr;

	// Bank selects the upper half of the array
	assign wrAddr = {palWr.bank, palWr.index};
	assign rdAddr = {palBank, pixIn.index};

	// ======================================================================
	// CPU write port
	// ======================================================================
	always_ff @(posedge CLK_48M) begin
		if (palWr.strobe) begin
			palMem[wrAddr] <= palWr.data;
		end
	end

	// ======================================================================
	// Pixel read port
	// ======================================================================
	// A write to the same word in this cycle is not seen here yet
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			palData   <= '0;
			blankHOut <= 1'b0;
			blankVOut <= 1'b0;
		end else if (pixelCe) begin
			palData   <= palMem[rdAddr];
			// Blanks ride along with the looked-up word
			blankHOut <= pixIn.hBlank;
			blankVOut <= pixIn.vBlank;
		end
	end

endmodule

// ==== rtl/pixelClockGen.sv ====
`timescale 1ns/1ns
`include "video_cfg.svh"

module pixelClockGen (
	input  logic CLK_48M,
	input  logic nRESET,
	output logic pixelCe
);

	localparam int CntW = $clog2(`PIXEL_DIV);
	localparam logic [CntW-1:0] LastCount = CntW'(`PIXEL_DIV - 1);

	logic [CntW-1:0] divCount;

	// Free-running divider that restarts from zero after reset
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			divCount <= '0;
		end else if (divCount == LastCount) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + CntW'(1);
		end
	end

	// High on the last count, so the first pulse lands on the eighth cycle
	assign pixelCe = (divCount == LastCount);

endmodule

// ==== rtl/cpuBusPkg.sv ====
`include "video_cfg.svh"

// CPU side of the colour stage
package cpuBusPkg;

	// Single palette write from the 68k bus
	// strobe is high for exactly one CLK_48M cycle per word
	typedef struct packed {
		logic                          strobe;
		logic [$clog2(`PAL_BANKS)-1:0] bank;
		logic [`PAL_INDEX_W-1:0]       index;
		videoPkg::palWord              data;
	} palWrite;

endpackage

// ==== rtl/videoPkg.sv ====
`include "video_cfg.svh"

// Pixel side of the colour stage
package videoPkg;

	// ======================================================================
	// Palette word layout
	// ======================================================================
	//  bit 15      dark (one step down on every channel)
	//  bit 14      red extra low bit
	//  bit 13      green extra low bit
	//  bit 12      blue extra low bit
	//  bits 11..8  red
	//  bits 7..4   green
	//  bits 3..0   blue
	typedef logic [`PAL_WORD_W-1:0] palWord;

	// Final colour as sent to the video DAC
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888;

	// One pixel as handed over by the renderer
	typedef struct packed {
		logic [`PAL_INDEX_W-1:0] index;
		logic                    hBlank;
		logic                    vBlank;
	} pixelReq;

	// Registered output pixel with blanks kept aligned to the colour
	typedef struct packed {
		rgb888 color;
		logic  hBlank;
		logic  vBlank;
	} pixelOut;

endpackage

// ==== include/video_cfg.svh ====
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// ======================================================================
// Palette geometry
// ======================================================================

// Index from the line renderer selects one word inside a bank
`define PAL_INDEX_W 12

// Two banks switched by the palette-bank level
`define PAL_BANKS 2

// Palette word with the dark bit on top and then extra low bits and R G B
`define PAL_WORD_W 16

// ======================================================================
// Pixel timing
// ======================================================================

// 48 MHz master clock down to the 6 MHz dot rate
`define PIXEL_DIV 8

`endif
